// ==== compile.f ====
+incdir+include
src/lcd_timing_pkg.sv
src/frame_pkg.sv
src/display_timing.sv
src/image_rom.sv
src/image_loader.sv
src/vram_arbiter.sv
src/video_ram.sv
src/pixel_pipeline.sv
src/lcd_top.sv
verification/lcd_tb.sv

// ==== include/lcd_macros.svh ====
`ifndef LCD_MACROS_SVH
`define LCD_MACROS_SVH

// Visible raster
`define H_ACTIVE 160
`define V_ACTIVE 96

// Horizontal porches and sync pulse, in pixels
`define H_FRONT 4
`define H_SYNC 4
`define H_BACK 8
`define H_TOTAL (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

// Vertical porches and sync pulse, in lines
`define V_FRONT 2
`define V_SYNC 2
`define V_BACK 4
`define V_TOTAL (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

// Image window inside the visible area
`define START_X 16
`define STOP_X 144
`define START_Y 16
`define STOP_Y 80

// Each stored word covers a 4x4 block
`define SCALE_SHIFT 2

// Video memory, 32 x 16 cells
`define VRAM_DEPTH 512
`define VRAM_AW 9
`define WORD_W 9

// Panel colour channels
`define R_W 5
`define G_W 6
`define B_W 5

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Build the Verilator model of lcd_tb, run it and look for the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
	-f compile.f --top-module lcd_tb -o lcd_sim > build.log 2>&1 &&
	./obj_dir/lcd_sim > sim.log 2>&1
grep -q "^STATUS: PASS$" sim.log 2>/dev/null && echo "simulation passed" && exit 0 ||
	{ echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== src/display_timing.sv ====
`include "lcd_macros.svh"

module display_timing (
	input logic pixel_clk,
	input logic rst,
	output lcd_timing_pkg::raster_pos_t pos,
	output lcd_timing_pkg::sync_t sync
);

	localparam logic [15:0] H_LAST = 16'(`H_TOTAL - 1);
	localparam logic [15:0] V_LAST = 16'(`V_TOTAL - 1);
	localparam logic [15:0] HS_START = 16'(`H_ACTIVE + `H_FRONT);
	localparam logic [15:0] HS_END = 16'(`H_ACTIVE + `H_FRONT + `H_SYNC);
	localparam logic [15:0] VS_START = 16'(`V_ACTIVE + `V_FRONT);
	localparam logic [15:0] VS_END = 16'(`V_ACTIVE + `V_FRONT + `V_SYNC);

	lcd_timing_pkg::raster_pos_t cnt;

	// Line steps at each pixel wrap
	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			cnt <= '0;
		end else if (cnt.x == H_LAST) begin
			cnt.x <= '0;
			if (cnt.y == V_LAST) begin
				cnt.y <= '0;
			end else begin
				cnt.y <= cnt.y + 16'd1;
			end
		end else begin
			cnt.x <= cnt.x + 16'd1;
		end
	end

	assign pos = cnt;

	always_comb begin
		sync.hsync = !((cnt.x >= HS_START) && (cnt.x < HS_END));
		sync.vsync = !((cnt.y >= VS_START) && (cnt.y < VS_END));
		sync.den = (cnt.x < 16'(`H_ACTIVE)) && (cnt.y < 16'(`V_ACTIVE));
	end

	// No data while a sync pulse is active
	den_outside_sync: assert property (
		@(posedge pixel_clk) disable iff (!rst)
		sync.den |-> (sync.hsync && sync.vsync)
	) else $error("den high during a sync pulse");

endmodule

// ==== src/frame_pkg.sv ====
`include "lcd_macros.svh"

package frame_pkg;

	// One panel pixel, RGB565 style
	typedef struct packed {
		logic [`R_W-1:0] r;
		logic [`G_W-1:0] g;
		logic [`B_W-1:0] b;
	} rgb_t;

	// Single access to the video RAM port
	typedef struct packed {
		logic [`VRAM_AW-1:0] addr;
		logic [`WORD_W-1:0] wdata;
		logic we; // High for a write
	} vram_req_t;

	// Loader states, IDLE primes the ROM read
	typedef enum logic [1:0] {
		IDLE,
		COPY,
		DONE
	} load_state_t;

endpackage

// ==== src/image_loader.sv ====
`include "lcd_macros.svh"

module image_loader (
	input logic pixel_clk,
	input logic rst,
	input logic reload,
	output logic load_req,
	output frame_pkg::vram_req_t load,
	input logic load_gnt,
	output logic busy
);

	localparam logic [`VRAM_AW-1:0] LAST_ADDR = `VRAM_AW'(`VRAM_DEPTH - 1);

	frame_pkg::load_state_t state;
	logic [`VRAM_AW-1:0] wr_addr;
	logic [`VRAM_AW-1:0] rom_addr;
	logic [`WORD_W-1:0] rom_data;
	logic step;

	assign load_req = (state == frame_pkg::COPY);
	assign step = load_req && load_gnt;
	assign busy = (state != frame_pkg::DONE);

	// ROM runs one word ahead, and holds when the grant is missing
	assign rom_addr = step ? wr_addr + 1'b1 : wr_addr;
	assign load = '{addr: wr_addr, wdata: rom_data, we: 1'b1};

	image_rom rom_i (
		.pixel_clk(pixel_clk),
		.addr(rom_addr),
		.data(rom_data)
	);

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			state <= frame_pkg::IDLE;
			wr_addr <= '0;
		end else begin
			case (state)
				frame_pkg::IDLE: state <= frame_pkg::COPY; // ROM word 0 ready next
				frame_pkg::COPY: begin
					if (step) begin
						if (wr_addr == LAST_ADDR) begin
							state <= frame_pkg::DONE;
						end else begin
							wr_addr <= wr_addr + 1'b1;
						end
					end
				end
				frame_pkg::DONE: begin
					if (reload) begin
						state <= frame_pkg::IDLE;
						wr_addr <= '0;
					end
				end
				default: state <= frame_pkg::IDLE;
			endcase
		end
	end

	req_held: assert property (
		@(posedge pixel_clk) disable iff (!rst)
		(load_req && !load_gnt) |=> (load_req && $stable(load))
	) else $error("load request changed before grant");

endmodule

// ==== src/image_rom.sv ====
`include "lcd_macros.svh"

module image_rom (
	input logic pixel_clk,
	input logic [`VRAM_AW-1:0] addr,
	output logic [`WORD_W-1:0] data
);

	typedef logic [`WORD_W-1:0] rom_table_t [`VRAM_DEPTH];

	// Test image, addr*7 + addr/32 folded to 9 bits
	function automatic rom_table_t build_table();
		rom_table_t t;
		for (int a = 0; a < `VRAM_DEPTH; a++) begin
			t[a] = `WORD_W'((a * 7) + (a >> 5));
		end
		return t;
	endfunction

	localparam rom_table_t TABLE = build_table();

	always_ff @(posedge pixel_clk) begin
		data <= TABLE[addr]; // One cycle latency
	end

endmodule

// ==== src/lcd_timing_pkg.sv ====
package lcd_timing_pkg;

	// Current raster position, pixel and line
	typedef struct packed {
		logic [15:0] x;
		logic [15:0] y;
	} raster_pos_t;

	// Panel control lines
	typedef struct packed {
		logic hsync; // Active low
		logic vsync; // Active low
		logic den; // Active high
	} sync_t;

endpackage

// ==== src/lcd_top.sv ====
`include "lcd_macros.svh"

module lcd_top (
	input logic pixel_clk,
	input logic rst,
	input logic reload,
	output logic lcd_hsync,
	output logic lcd_vsync,
	output logic lcd_den,
	output logic [`R_W-1:0] lcd_r,
	output logic [`G_W-1:0] lcd_g,
	output logic [`B_W-1:0] lcd_b,
	output logic load_busy
);

	lcd_timing_pkg::raster_pos_t pos;
	lcd_timing_pkg::sync_t sync;
	lcd_timing_pkg::sync_t sync_out;
	frame_pkg::vram_req_t fetch;
	frame_pkg::vram_req_t load;
	frame_pkg::vram_req_t port;
	frame_pkg::rgb_t pixel;
	logic fetch_req;
	logic load_req;
	logic load_gnt;
	logic [`WORD_W-1:0] rdata;

	display_timing timing_i (
		.pixel_clk(pixel_clk),
		.rst(rst),
		.pos(pos),
		.sync(sync)
	);

	pixel_pipeline pipe_i (
		.pixel_clk(pixel_clk),
		.rst(rst),
		.pos(pos),
		.sync(sync),
		.fetch_req(fetch_req),
		.fetch(fetch),
		.rdata(rdata),
		.pixel(pixel),
		.sync_out(sync_out)
	);

	image_loader loader_i (
		.pixel_clk(pixel_clk),
		.rst(rst),
		.reload(reload),
		.load_req(load_req),
		.load(load),
		.load_gnt(load_gnt),
		.busy(load_busy)
	);

	// Fetch grant equals its request, pipeline needs no return
	vram_arbiter arb_i (
		.pixel_clk(pixel_clk),
		.rst(rst),
		.fetch_req(fetch_req),
		.fetch(fetch),
		.load_req(load_req),
		.load(load),
		.fetch_gnt(),
		.load_gnt(load_gnt),
		.port(port)
	);

	video_ram vram_i (
		.pixel_clk(pixel_clk),
		.port(port),
		.rdata(rdata)
	);

	assign lcd_hsync = sync_out.hsync;
	assign lcd_vsync = sync_out.vsync;
	assign lcd_den = sync_out.den;
	assign lcd_r = pixel.r;
	assign lcd_g = pixel.g;
	assign lcd_b = pixel.b;

endmodule

// ==== src/pixel_pipeline.sv ====
`include "lcd_macros.svh"

module pixel_pipeline (
	input logic pixel_clk,
	input logic rst,
	input lcd_timing_pkg::raster_pos_t pos,
	input lcd_timing_pkg::sync_t sync,
	output logic fetch_req,
	output frame_pkg::vram_req_t fetch,
	input logic [`WORD_W-1:0] rdata,
	output frame_pkg::rgb_t pixel,
	output lcd_timing_pkg::sync_t sync_out
);

	localparam int COL_W = $clog2((`STOP_X - `START_X) >> `SCALE_SHIFT);
	localparam int ROW_W = `VRAM_AW - COL_W;
	localparam lcd_timing_pkg::sync_t SYNC_IDLE = '{hsync: 1'b1, vsync: 1'b1, den: 1'b0};

	logic in_win;
	logic [15:0] col_off;
	logic [15:0] row_off;
	logic win_q;
	logic [15:0] grad_q;
	lcd_timing_pkg::sync_t sync_q;
	frame_pkg::rgb_t colour;

	assign in_win = (pos.x >= 16'(`START_X)) && (pos.x < 16'(`STOP_X)) &&
		(pos.y >= 16'(`START_Y)) && (pos.y < 16'(`STOP_Y));
	assign col_off = pos.x - 16'(`START_X);
	assign row_off = pos.y - 16'(`START_Y);

	// Stage one, RAM address issued this cycle
	assign fetch_req = in_win;
	assign fetch = '{
		addr: {row_off[`SCALE_SHIFT +: ROW_W], col_off[`SCALE_SHIFT +: COL_W]},
		wdata: '0,
		we: 1'b0
	};

	always_comb begin
		if (!sync_q.den) begin
			colour = '0; // Blanking
		end else if (win_q) begin
			colour.r = rdata[`WORD_W-1 -: `R_W];
			colour.g = rdata[`WORD_W-1 -: `G_W];
			colour.b = rdata[`WORD_W-1 -: `B_W];
		end else begin
			colour.r = grad_q[`R_W-1:0];
			colour.g = grad_q[`R_W +: `G_W];
			colour.b = grad_q[`R_W + `G_W +: `B_W];
		end
	end

	always_ff @(posedge pixel_clk) begin
		win_q <= in_win;
		grad_q <= pos.x + pos.y;
		pixel <= colour; // Stage two
	end

	// Sync follows the colour through both stages
	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			sync_q <= SYNC_IDLE;
			sync_out <= SYNC_IDLE;
		end else begin
			sync_q <= sync;
			sync_out <= sync_q;
		end
	end

endmodule

// ==== src/video_ram.sv ====
`include "lcd_macros.svh"

module video_ram (
	input logic pixel_clk,
	input frame_pkg::vram_req_t port,
	output logic [`WORD_W-1:0] rdata
);

	logic [`WORD_W-1:0] mem [`VRAM_DEPTH];

	// Read data holds during a write cycle
	always_ff @(posedge pixel_clk) begin
		if (port.we) begin
			mem[port.addr] <= port.wdata;
		end else begin
			rdata <= mem[port.addr];
		end
	end

endmodule

// ==== src/vram_arbiter.sv ====
`include "lcd_macros.svh"

module vram_arbiter (
	input logic pixel_clk,
	input logic rst,
	input logic fetch_req,
	input frame_pkg::vram_req_t fetch,
	input logic load_req,
	input frame_pkg::vram_req_t load,
	output logic fetch_gnt,
	output logic load_gnt,
	output frame_pkg::vram_req_t port
);

	// Last credited write
	typedef struct packed {
		logic load;
		logic [`VRAM_AW-1:0] addr;
	} grant_rec_t;

	grant_rec_t rec_q;
	logic repeat_wr;

	assign repeat_wr = rec_q.load && (load.addr == rec_q.addr);

	// Fetch first, loader fills the gaps
	assign fetch_gnt = fetch_req;
	assign load_gnt = load_req && !fetch_req && !repeat_wr;

	always_comb begin
		if (fetch_gnt) begin
			port = fetch;
		end else if (load_gnt) begin
			port = load;
		end else begin
			port = '0; // Idle read of word 0
		end
	end

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			rec_q <= '0;
		end else begin
			rec_q.load <= load_gnt;
			rec_q.addr <= load.addr;
		end
	end

	gnt_onehot: assert property (
		@(posedge pixel_clk) disable iff (!rst)
		!(fetch_gnt && load_gnt)
	) else $error("both RAM grants high");

endmodule

// ==== verification/lcd_golden.txt ====
# Columns: command, then for expect only: test name, x, y, r, g, b (decimal)
# Commands: reload, wait_load, expect; run in file order
wait_load
expect grad_origin 0 0 0 0 0
expect grad_top 100 5 9 3 0
expect grad_left 3 40 11 1 0
expect grad_left_edge 15 16 31 0 0
expect grad_right_edge 144 16 0 5 0
expect grad_corner 159 95 30 7 0
expect cell37_tl 36 20 16 32 16
expect cell37_tr 39 20 16 32 16
expect cell37_bl 36 23 16 32 16
expect cell37_br 39 23 16 32 16
expect cell100 33 29 11 23 11
expect cell511 143 79 0 1 0
reload
wait_load
expect reload_cell200 49 41 23 47 23
expect reload_cell300 64 52 3 7 3
expect reload_cell450 27 75 5 11 5
expect reload_cell37 37 22 16 32 16
expect reload_grad 150 90 16 7 0

// ==== verification/lcd_tb.sv ====
`include "lcd_macros.svh"

module lcd_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int FRAME_NS = `H_TOTAL * `V_TOTAL * 8;
	localparam lcd_timing_pkg::sync_t SYNC_IDLE = '{hsync: 1'b1, vsync: 1'b1, den: 1'b0};

	logic pixel_clk = 1'b0;
	logic rst;
	logic reload;
	logic lcd_hsync;
	logic lcd_vsync;
	logic lcd_den;
	logic [`R_W-1:0] lcd_r;
	logic [`G_W-1:0] lcd_g;
	logic [`B_W-1:0] lcd_b;
	logic load_busy;

	string lines[$];
	int cmd_total = 0;
	logic mon_on = 1'b0;
	lcd_timing_pkg::sync_t cur_sync;
	lcd_timing_pkg::sync_t prev_sync = SYNC_IDLE;
	frame_pkg::rgb_t cur_rgb;
	frame_pkg::rgb_t pix_rgb;
	logic pix_den = 1'b0;
	int pix_x = 0;
	int pix_y = 0;
	int row_cnt = 0; // den rows since vsync
	int h_low = 0;
	int v_low = 0;
	int den_len = 0;
	int line_len = 0;
	int frame_len = 0;
	logic line_seen = 1'b0;
	logic frame_seen = 1'b0;

	lcd_top dut_i (.*);

	always #4 pixel_clk = ~pixel_clk;

	task automatic stop_run();
		$display("STATUS: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_rgb(input string name, input frame_pkg::rgb_t exp,
		input frame_pkg::rgb_t act);
		if (act !== exp) begin
			$display("Fail %s expected r=%0d g=%0d b=%0d actual r=%0d g=%0d b=%0d",
				name, exp.r, exp.g, exp.b, act.r, act.g, act.b);
			stop_run();
		end
	endtask

	task automatic check_sync(input string name, input lcd_timing_pkg::sync_t exp,
		input lcd_timing_pkg::sync_t act);
		if (act !== exp) begin
			$display("Fail %s expected hsync=%b vsync=%b den=%b actual hsync=%b vsync=%b den=%b",
				name, exp.hsync, exp.vsync, exp.den, act.hsync, act.vsync, act.den);
			stop_run();
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("Fail %s expected %0d actual %0d", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Fail %s expected %b actual %b", name, exp, act);
			stop_run();
		end
	endtask

	function automatic lcd_timing_pkg::sync_t sample_sync();
		return '{hsync: lcd_hsync, vsync: lcd_vsync, den: lcd_den};
	endfunction

	function automatic frame_pkg::rgb_t sample_rgb();
		return '{r: lcd_r, g: lcd_g, b: lcd_b};
	endfunction

	task automatic read_golden();
		int fd;
		string line;
		string word;
		fd = $fopen("verification/lcd_golden.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the golden file verification/lcd_golden.txt");
			stop_run();
		end
		while ($fgets(line, fd) > 0) begin
			if ($sscanf(line, "%s", word) == 1 && word.substr(0, 0) != "#") begin
				lines.push_back(line); // Comment and blank lines dropped
			end
		end
		$fclose(fd);
		if (lines.size() == 0) begin
			$display("The golden file holds no commands");
			stop_run();
		end
		cmd_total = lines.size();
	endtask

	task automatic pulse_reload();
		@(posedge pixel_clk);
		while (!(pix_den && pix_x == 0 && pix_y == `START_Y)) begin
			@(posedge pixel_clk); // Copy then overlaps the window fetches
		end
		#1 reload = 1'b1;
		@(posedge pixel_clk);
		#1 reload = 1'b0;
		check_flag("reload_busy", 1'b1, load_busy);
	endtask

	task automatic wait_load_done();
		int cycles;
		cycles = 0;
		while (load_busy) begin
			@(posedge pixel_clk);
			#1;
			cycles++;
		end
		if (cycles < `VRAM_DEPTH) begin
			$display("Image load ended after %0d cycles, too fast for %0d words",
				cycles, `VRAM_DEPTH);
			stop_run();
		end
	endtask

	// Positions are tracked at negedge, so read here at posedge
	task automatic expect_pixel(input string name, input int x, input int y,
		input frame_pkg::rgb_t exp);
		@(posedge pixel_clk);
		while (!(pix_den && pix_x == x && pix_y == y)) begin
			@(posedge pixel_clk);
		end
		check_rgb(name, exp, pix_rgb);
	endtask

	task automatic run_command(input string line);
		string cmd;
		string name;
		int x, y, r, g, b;
		frame_pkg::rgb_t exp_rgb;
		void'($sscanf(line, "%s", cmd));
		if (cmd == "reload") begin
			pulse_reload();
		end else if (cmd == "wait_load") begin
			wait_load_done();
		end else if (cmd != "expect") begin
			$display("Unknown command in the golden file: %s", cmd);
			stop_run();
		end else if ($sscanf(line, "%s %s %d %d %d %d %d", cmd, name, x, y, r, g, b) != 7) begin
			$display("Malformed expect line in the golden file: %s", line);
			stop_run();
		end else begin
			exp_rgb.r = r[`R_W-1:0];
			exp_rgb.g = g[`G_W-1:0];
			exp_rgb.b = b[`B_W-1:0];
			expect_pixel(name, x, y, exp_rgb);
		end
	endtask

	// Raster checks and position tracking from the panel pins
	always @(negedge pixel_clk) begin
		if (mon_on) begin
			cur_sync = sample_sync();
			cur_rgb = sample_rgb();
			if (!cur_sync.den) begin
				check_rgb("blank_black", '0, cur_rgb);
			end
			if (!cur_sync.hsync && prev_sync.hsync) begin
				if (line_seen) begin
					check_count("line_period", `H_TOTAL, line_len);
				end
				line_seen = 1'b1;
				line_len = 0;
			end
			if (cur_sync.hsync && !prev_sync.hsync) begin
				check_count("hsync_width", `H_SYNC, h_low);
			end
			if (!cur_sync.den && prev_sync.den) begin
				check_count("den_width", `H_ACTIVE, den_len);
				row_cnt++;
			end
			if (cur_sync.den && !prev_sync.den) begin
				pix_x = 0; // Column restarts at den rise
				pix_y = row_cnt;
			end else if (cur_sync.den) begin
				pix_x++;
			end
			if (!cur_sync.vsync && prev_sync.vsync) begin
				check_count("visible_lines", `V_ACTIVE, row_cnt);
				if (frame_seen) begin
					check_count("frame_period", `V_TOTAL * `H_TOTAL, frame_len);
				end
				frame_seen = 1'b1;
				frame_len = 0;
			end
			if (cur_sync.vsync && !prev_sync.vsync) begin
				check_count("vsync_width", `V_SYNC * `H_TOTAL, v_low);
			end
			if (!cur_sync.vsync) begin
				row_cnt = 0;
			end
			h_low = cur_sync.hsync ? 0 : h_low + 1;
			v_low = cur_sync.vsync ? 0 : v_low + 1;
			den_len = cur_sync.den ? den_len + 1 : 0;
			line_len++;
			frame_len++;
			pix_den = cur_sync.den;
			pix_rgb = cur_rgb;
			prev_sync = cur_sync;
		end
	end

	initial begin
		wait (cmd_total > 0);
		#(cmd_total * 4 * FRAME_NS);
		$display("Timeout: the golden commands did not finish within %0d frame times",
			cmd_total * 4);
		stop_run();
	end

	initial begin
		rst = 1'b0;
		reload = 1'b0;
		read_golden();
		repeat (8) @(posedge pixel_clk);
		#1;
		check_sync("reset_sync", SYNC_IDLE, sample_sync());
		check_rgb("reset_black", '0, sample_rgb());
		check_flag("reset_busy", 1'b1, load_busy);
		rst = 1'b1;
		@(posedge pixel_clk);
		#1;
		check_sync("idle_before_den", SYNC_IDLE, sample_sync());
		check_rgb("black_before_den", '0, sample_rgb());
		check_flag("busy_before_den", 1'b1, load_busy);
		mon_on = 1'b1;
		foreach (lines[i]) begin
			run_command(lines[i]);
		end
		$display("STATUS: PASS");
		$finish;
	end

endmodule
